/* vending_machine.f */
+incdir+rtl
rtl/vend_pkg.sv
rtl/coin_acceptor.sv
rtl/product_stock.sv
rtl/change_dispenser.sv
rtl/vending_machine.sv
sim/vending_machine_tb.sv

/* sim/vending_machine_tb.sv */
`timescale 1ns/1ps
`include "vend_config.svh"

module vending_machine_tb;

	localparam int         NUM_TESTS      = 14;
	localparam int         TIMEOUT_CYCLES = 200;
	localparam logic [1:0] ACT_SELECT     = 2'd1;
	localparam logic [1:0] ACT_CANCEL     = 2'd2;
	localparam logic [2:0] NO_DEL         = 3'd4;

	// Coin nibbles, lowest first, hold 0 for no coin or denomination index plus one
	typedef struct packed
	{
		logic [31:0] coins;
		logic [1:0]  action;
		logic [1:0]  prod;
		logic [2:0]  exp_del;
		logic        ret_fixed;
		logic [15:0] exp_ret;
		logic        busy_coin;
	} entry_t;

	logic                      can;
	logic                      reset;
	logic [3:0]                coin_in;
	logic [3:0]                select;
	logic                      cancel;
	logic [`VEND_CREDIT_W-1:0] credit;
	logic [3:0]                deliver;
	logic [3:0]                sold_out;
	logic [3:0]                return_coin;
	logic                      busy;
	logic                      change_short;

	entry_t      tests [NUM_TESTS];
	logic [31:0] rng_state;
	int          check_errors;
	int          tests_passed;
	int          tests_failed;
	bit          timed_out;

	// Reference model of the machine contents
	int m_credit;
	int m_stock [4];
	int m_inv [4];
	int m_ins [4];
	bit m_short;
	int m_ret [4];
	bit m_pay;

	vending_machine vending_machine_i (
		.can         (can),
		.reset       (reset),
		.coin_in     (coin_in),
		.select      (select),
		.cancel      (cancel),
		.credit      (credit),
		.deliver     (deliver),
		.sold_out    (sold_out),
		.return_coin (return_coin),
		.busy        (busy),
		.change_short(change_short)
	);

	always #20 can = ~can;

	function automatic int coin_value(input int d);
		case (d)
			0: return `VEND_COIN_VAL_5;
			1: return `VEND_COIN_VAL_10;
			2: return `VEND_COIN_VAL_20;
			default: return `VEND_COIN_VAL_50;
		endcase
	endfunction

	function automatic int price_of(input int p);
		case (p)
			0: return `VEND_PRICE_0;
			1: return `VEND_PRICE_1;
			2: return `VEND_PRICE_2;
			default: return `VEND_PRICE_3;
		endcase
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic entry_t make_entry(
		input logic [31:0] coins,
		input logic [1:0]  action,
		input logic [1:0]  prod,
		input logic [2:0]  exp_del,
		input logic        ret_fixed,
		input logic [15:0] exp_ret,
		input logic        busy_coin
	);
		entry_t e;
		e.coins     = coins;
		e.action    = action;
		e.prod      = prod;
		e.exp_del   = exp_del;
		e.ret_fixed = ret_fixed;
		e.exp_ret   = exp_ret;
		e.busy_coin = busy_coin;
		return e;
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////

	task automatic model_coin(input int d);
		if (m_credit + coin_value(d) <= `VEND_CREDIT_MAX)
		begin
			m_credit = m_credit + coin_value(d);
			m_ins[d]++;
		end
	endtask

	// Greedy change from the largest coin held, inserted coins included
	task automatic model_select(input int p);
		int remain;
		for (int d = 0; d < 4; d++)
			m_ret[d] = 0;
		m_pay = 1'b0;
		if (m_stock[p] > 0 && m_credit >= price_of(p))
		begin
			m_stock[p]--;
			remain = m_credit - price_of(p);
			m_pay  = (remain != 0);
			for (int d = 0; d < 4; d++)
			begin
				m_inv[d] = m_inv[d] + m_ins[d];
				m_ins[d] = 0;
			end
			for (int d = 3; d >= 0; d--)
			begin
				while (m_inv[d] > 0 && coin_value(d) <= remain)
				begin
					m_inv[d]--;
					m_ret[d]++;
					remain = remain - coin_value(d);
				end
			end
			m_short  = (remain != 0);
			m_credit = 0;
		end
	endtask

	task automatic model_cancel();
		for (int d = 0; d < 4; d++)
			m_ret[d] = 0;
		m_pay = (m_credit != 0);
		if (m_credit != 0)
		begin
			for (int d = 0; d < 4; d++)
			begin
				m_ret[d] = m_ins[d];
				m_ins[d] = 0;
			end
			m_credit = 0;
			m_short  = 1'b0;
		end
	endtask

	task automatic check_equal(input string name, input int t, input logic [31:0] exp,
		input logic [31:0] got);
		if (exp !== got)
		begin
			$display("CHECK FAILED test %0d %s: expected %0h got %0h", t, name, exp, got);
			check_errors++;
		end
	endtask

	task automatic insert_coin(input int t, input int d);
		coin_in = 4'b0001 << d;
		model_coin(d);
		@(posedge can);
		@(negedge can);
		coin_in = 4'b0000;
		check_equal("credit", t, m_credit, credit);
	endtask

	//////////////////////////////
	// One table entry
	//////////////////////////////

	task automatic run_test(input int t);
		entry_t     e;
		int         code;
		int         got_ret [4];
		int         del_cnt;
		logic [3:0] del_seen;
		logic [3:0] del_exp;
		logic [3:0] so_exp;
		int         cycles;
		int         errors_before;
		int         exp_cnt;

		e             = tests[t];
		errors_before = check_errors;
		del_cnt       = 0;
		del_seen      = 4'b0000;
		for (int d = 0; d < 4; d++)
			got_ret[d] = 0;
		for (int i = 0; i < 8; i++)
		begin
			code = e.coins[i*4 +: 4];
			if (code != 0)
				insert_coin(t, code - 1);
		end

		if (e.action == ACT_SELECT)
		begin
			select = 4'b0001 << e.prod;
			model_select(e.prod);
		end
		else
		begin
			cancel = 1'b1;
			model_cancel();
		end
		@(posedge can);
		@(negedge can);
		select = 4'b0000;
		cancel = 1'b0;
		if (deliver != 4'b0000)
		begin
			del_cnt++;
			del_seen = del_seen | deliver;
		end
		check_equal("busy", t, 32'd0, busy);
		@(posedge can);
		@(negedge can);

		// Payout runs until busy falls
		// A coin sent during it must be ignored
		cycles = 0;
		while (busy && cycles < TIMEOUT_CYCLES)
		begin
			for (int d = 0; d < 4; d++)
				if (return_coin[d])
					got_ret[d]++;
			if (deliver != 4'b0000)
				del_cnt++;
			coin_in = (e.busy_coin && cycles == 0) ? 4'b0010 : 4'b0000;
			@(posedge can);
			@(negedge can);
			cycles++;
		end
		coin_in = 4'b0000;
		if (busy)
		begin
			$display("Test %0d: busy did not fall within %0d cycles", t, TIMEOUT_CYCLES);
			timed_out = 1'b1;
			check_errors++;
		end

		check_equal("busy", t, m_pay, cycles != 0);
		del_exp = (e.exp_del == NO_DEL) ? 4'b0000 : (4'b0001 << e.exp_del);
		check_equal("deliver", t, del_exp, del_seen);
		if (del_cnt > 1)
		begin
			$display("Test %0d: deliver pulsed %0d times instead of once", t, del_cnt);
			check_errors++;
		end
		for (int d = 0; d < 4; d++)
		begin
			exp_cnt = e.ret_fixed ? int'(e.exp_ret[d*4 +: 4]) : m_ret[d];
			check_equal($sformatf("return_coin[%0d] count", d), t, exp_cnt, got_ret[d]);
		end
		for (int p = 0; p < 4; p++)
			so_exp[p] = (m_stock[p] == 0);
		check_equal("credit", t, m_credit, credit);
		check_equal("sold_out", t, so_exp, sold_out);
		check_equal("change_short", t, m_short, change_short);

		if (check_errors == errors_before)
		begin
			tests_passed++;
			$display("Test %0d ok", t);
		end
		else
		begin
			tests_failed++;
			$display("Test %0d failed with %0d errors", t, check_errors - errors_before);
		end
	endtask

	initial
	begin
		logic [31:0] fill;
		int          n_coins;

		can          = 1'b0;
		reset        = 1'b1;
		coin_in      = 4'b0000;
		select       = 4'b0000;
		cancel       = 1'b0;
		rng_state    = 32'd27819;
		check_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		m_credit     = 0;
		m_short      = 1'b0;
		m_pay        = 1'b0;
		for (int p = 0; p < 4; p++)
		begin
			m_stock[p] = `VEND_STOCK_INIT;
			m_inv[p]   = `VEND_INV_INIT;
			m_ins[p]   = 0;
			m_ret[p]   = 0;
		end

		// Credit build-up with one coin past the cap, then cancel
		tests[0]  = make_entry(32'h1234_4321, ACT_CANCEL, 2'd0, NO_DEL, 1'b1, 16'h2122, 1'b0);
		tests[1]  = make_entry(32'h12, ACT_SELECT, 2'd0, 3'd0, 1'b1, 16'h0000, 1'b0);
		tests[2]  = make_entry(32'h44, ACT_SELECT, 2'd1, 3'd1, 1'b1, 16'h1011, 1'b0);
		tests[3]  = make_entry(32'h3, ACT_SELECT, 2'd2, NO_DEL, 1'b1, 16'h0000, 1'b0);
		tests[4]  = make_entry(32'h23, ACT_SELECT, 2'd2, 3'd2, 1'b1, 16'h0000, 1'b0);
		tests[5]  = make_entry(32'h422, ACT_CANCEL, 2'd0, NO_DEL, 1'b1, 16'h1020, 1'b1);
		// Product 0 runs out, then change runs short
		tests[8]  = make_entry(32'h3, ACT_SELECT, 2'd0, 3'd0, 1'b0, 16'h0000, 1'b0);
		tests[9]  = make_entry(32'h3, ACT_SELECT, 2'd0, 3'd0, 1'b0, 16'h0000, 1'b0);
		tests[10] = make_entry(32'h3, ACT_SELECT, 2'd0, NO_DEL, 1'b0, 16'h0000, 1'b0);
		tests[11] = make_entry(32'h0, ACT_CANCEL, 2'd0, NO_DEL, 1'b0, 16'h0000, 1'b0);
		tests[12] = make_entry(32'h33, ACT_SELECT, 2'd1, 3'd1, 1'b0, 16'h0000, 1'b0);
		tests[13] = make_entry(32'h4, ACT_SELECT, 2'd1, 3'd1, 1'b1, 16'h0010, 1'b0);

		for (int f = 6; f < 8; f++)
		begin
			n_coins = 1 + next_random() % 3;
			fill    = 32'h0;
			for (int i = 0; i < n_coins; i++)
				fill[i*4 +: 4] = 1 + next_random() % 4;
			tests[f] = make_entry(fill, ACT_CANCEL, 2'd0, NO_DEL, 1'b0, 16'h0000, 1'b0);
		end

		repeat (2) @(posedge can);
		@(negedge can);
		reset = 1'b0;

		for (int t = 0; t < NUM_TESTS && !timed_out; t++)
			run_test(t);

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && !timed_out)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* rtl/vending_machine.sv */
`timescale 1ns/1ps
`include "vend_config.svh"

module vending_machine
	import vend_pkg::*;
(
	input  logic       can,
	input  logic       reset,
	input  logic [3:0] coin_in,
	input  logic [3:0] select,
	input  logic       cancel,
	output credit_t    credit,
	output logic [3:0] deliver,
	output logic [3:0] sold_out,
	output logic [3:0] return_coin,
	output logic       busy,
	output logic       change_short
);

	count_t  ins_5;
	count_t  ins_10;
	count_t  ins_20;
	count_t  ins_50;
	logic    refund;
	logic    sale;
	credit_t change_due;

	coin_acceptor coin_acceptor_i (
		.can    (can),
		.reset  (reset),
		.coin_in(coin_in),
		.cancel (cancel),
		.busy   (busy),
		.sale   (sale),
		.credit (credit),
		.ins_5  (ins_5),
		.ins_10 (ins_10),
		.ins_20 (ins_20),
		.ins_50 (ins_50),
		.refund (refund)
	);

	product_stock product_stock_i (
		.can       (can),
		.reset     (reset),
		.select    (select),
		.credit    (credit),
		.busy      (busy),
		.deliver   (deliver),
		.sale      (sale),
		.change_due(change_due),
		.sold_out  (sold_out)
	);

	change_dispenser change_dispenser_i (
		.can         (can),
		.reset       (reset),
		.sale        (sale),
		.refund      (refund),
		.change_due  (change_due),
		.ins_5       (ins_5),
		.ins_10      (ins_10),
		.ins_20      (ins_20),
		.ins_50      (ins_50),
		.return_coin (return_coin),
		.busy        (busy),
		.change_short(change_short)
	);

endmodule

/* rtl/change_dispenser.sv */
`timescale 1ns/1ps
`include "vend_config.svh"

module change_dispenser
	import vend_pkg::*;
(
	input  logic       can,
	input  logic       reset,
	input  logic       sale,
	input  logic       refund,
	input  credit_t    change_due,
	input  count_t     ins_5,
	input  count_t     ins_10,
	input  count_t     ins_20,
	input  count_t     ins_50,
	output logic [3:0] return_coin,
	output logic       busy,
	output logic       change_short
);

	localparam credit_t coin_val [4] = '{
		credit_t'(`VEND_COIN_VAL_5),
		credit_t'(`VEND_COIN_VAL_10),
		credit_t'(`VEND_COIN_VAL_20),
		credit_t'(`VEND_COIN_VAL_50)
	};

	disp_state_e state;
	credit_t     remain;
	count_t      inv [4];
	count_t      rf_cnt [4];
	count_t      ins [4];
	logic        pick_ok;
	coin_e       pick;
	logic        rf_ok;
	coin_e       rf_pick;
	logic [2:0]  rf_nz;
	logic        refund_more;

	function automatic count_t sat_add(count_t a, count_t b);
		logic [`VEND_COUNT_W:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[`VEND_COUNT_W] ? '1 : s[`VEND_COUNT_W-1:0];
	endfunction

	assign ins[COIN_5]  = ins_5;
	assign ins[COIN_10] = ins_10;
	assign ins[COIN_20] = ins_20;
	assign ins[COIN_50] = ins_50;

	// Greedy pick of the largest coin held that still fits
	always_comb
	begin
		pick_ok = 1'b0;
		pick    = COIN_5;
		for (int i = 0; i < 4; i++)
		begin
			if (inv[i] != '0 && coin_val[i] <= remain)
			begin
				pick_ok = 1'b1;
				pick    = coin_e'(i);
			end
		end
	end

	// Refund order is smallest denomination first
	always_comb
	begin
		rf_ok   = 1'b0;
		rf_pick = COIN_50;
		rf_nz   = 3'd0;
		for (int i = 3; i >= 0; i--)
		begin
			if (rf_cnt[i] != '0)
			begin
				rf_ok   = 1'b1;
				rf_pick = coin_e'(i);
				rf_nz   = rf_nz + 3'd1;
			end
		end
		refund_more = (rf_nz > 3'd1) || (rf_cnt[rf_pick] > count_t'(1));
	end

	always_comb
	begin
		return_coin = 4'b0000;
		if (state == DISP_CHANGE && pick_ok)
			return_coin[pick] = 1'b1;
		else if (state == DISP_REFUND && rf_ok)
			return_coin[rf_pick] = 1'b1;
	end

	assign busy = (state != DISP_IDLE);

	//////////////////////////////
	// FSM and coin inventory
	//////////////////////////////

	always_ff @(posedge can or posedge reset)
	begin
		if (reset)
		begin
			state        <= DISP_IDLE;
			change_short <= 1'b0;
			inv          <= '{default: count_t'(`VEND_INV_INIT)};
		end
		else
		begin
			case (state)
				DISP_IDLE:
				begin
					if (refund)
					begin
						change_short <= 1'b0;
						state        <= DISP_REFUND;
					end
					else if (sale)
					begin
						change_short <= 1'b0;
						for (int i = 0; i < 4; i++)
							inv[i] <= sat_add(inv[i], ins[i]);
						if (change_due != '0)
							state <= DISP_CHANGE;
					end
				end
				DISP_CHANGE:
				begin
					if (pick_ok)
					begin
						inv[pick] <= inv[pick] - 1'b1;
						if (remain == coin_val[pick])
							state <= DISP_IDLE;
					end
					else
					begin
						// Change left but nothing fits
						change_short <= 1'b1;
						state        <= DISP_IDLE;
					end
				end
				DISP_REFUND:
				begin
					if (!refund_more)
						state <= DISP_IDLE;
				end
				default: state <= DISP_IDLE;
			endcase
		end
	end

	// Amount still owed is loaded while idle
	always_ff @(posedge can)
	begin
		if (state == DISP_IDLE)
		begin
			remain <= change_due;
			rf_cnt <= ins;
		end
		else if (state == DISP_CHANGE && pick_ok)
			remain <= remain - coin_val[pick];
		else if (state == DISP_REFUND && rf_ok)
			rf_cnt[rf_pick] <= rf_cnt[rf_pick] - 1'b1;
	end

	// Sale and refund only ever arrive one at a time into an idle dispenser
	assert property (@(posedge can) disable iff (reset)
		(sale || refund) |-> (state == DISP_IDLE) && !(sale && refund))
		else $error("sale %b refund %b in state %s", sale, refund, state.name());

endmodule

/* rtl/product_stock.sv */
`timescale 1ns/1ps
`include "vend_config.svh"

module product_stock
	import vend_pkg::*;
(
	input  logic       can,
	input  logic       reset,
	input  logic [3:0] select,
	input  credit_t    credit,
	input  logic       busy,
	output logic [3:0] deliver,
	output logic       sale,
	output credit_t    change_due,
	output logic [3:0] sold_out
);

	count_t     stock [4];
	logic [1:0] sel_idx;
	logic       sel_valid;
	credit_t    price;
	logic       sel_ok;

	//////////////////////////////
	// Price lookup
	//////////////////////////////

	always_comb
	begin
		sel_idx   = 2'd0;
		sel_valid = 1'b1;
		price     = credit_t'(`VEND_PRICE_0);
		case (select)
			4'b0001: sel_idx = 2'd0;
			4'b0010:
			begin
				sel_idx = 2'd1;
				price   = credit_t'(`VEND_PRICE_1);
			end
			4'b0100:
			begin
				sel_idx = 2'd2;
				price   = credit_t'(`VEND_PRICE_2);
			end
			4'b1000:
			begin
				sel_idx = 2'd3;
				price   = credit_t'(`VEND_PRICE_3);
			end
			default: sel_valid = 1'b0;
		endcase
	end

	assign sel_ok = sel_valid && !busy && !sale && (stock[sel_idx] != '0) && (credit >= price);

	//////////////////////////////
	// Stock and sale
	//////////////////////////////

	always_ff @(posedge can or posedge reset)
	begin
		if (reset)
		begin
			stock   <= '{default: count_t'(`VEND_STOCK_INIT)};
			deliver <= 4'b0000;
			sale    <= 1'b0;
		end
		else
		begin
			deliver <= 4'b0000;
			sale    <= sel_ok;
			if (sel_ok)
			begin
				deliver[sel_idx] <= 1'b1;
				stock[sel_idx]   <= stock[sel_idx] - 1'b1;
			end
		end
	end

	always_ff @(posedge can)
	begin
		if (sel_ok)
			change_due <= credit - price;
	end

	always_comb
	begin
		for (int i = 0; i < 4; i++)
			sold_out[i] = (stock[i] == '0);
	end

	// A product flagged sold out before the sale is never delivered
	assert property (@(posedge can) disable iff (reset)
		(deliver != 4'b0000) |-> $onehot(deliver) && ((deliver & $past(sold_out)) == 4'b0000))
		else $error("deliver %b not one-hot or for a sold-out product", deliver);

endmodule

/* rtl/coin_acceptor.sv */
`timescale 1ns/1ps
`include "vend_config.svh"

module coin_acceptor
	import vend_pkg::*;
(
	input  logic       can,
	input  logic       reset,
	input  logic [3:0] coin_in,
	input  logic       cancel,
	input  logic       busy,
	input  logic       sale,
	output credit_t    credit,
	output count_t     ins_5,
	output count_t     ins_10,
	output count_t     ins_20,
	output count_t     ins_50,
	output logic       refund
);

	logic                    idle;
	coin_e                   coin_idx;
	credit_t                 coin_val;
	logic [`VEND_CREDIT_W:0] credit_sum;
	logic                    coin_ok;
	logic                    cancel_ok;
	count_t                  ins_cnt [4];

	// Panel input only counts when nothing is in flight
	assign idle = !busy && !sale && !refund;

	always_comb
	begin
		coin_idx = COIN_5;
		coin_val = '0;
		case (coin_in)
			4'b0001:
			begin
				coin_idx = COIN_5;
				coin_val = credit_t'(`VEND_COIN_VAL_5);
			end
			4'b0010:
			begin
				coin_idx = COIN_10;
				coin_val = credit_t'(`VEND_COIN_VAL_10);
			end
			4'b0100:
			begin
				coin_idx = COIN_20;
				coin_val = credit_t'(`VEND_COIN_VAL_20);
			end
			4'b1000:
			begin
				coin_idx = COIN_50;
				coin_val = credit_t'(`VEND_COIN_VAL_50);
			end
			default: coin_val = '0;
		endcase
	end

	assign credit_sum = {1'b0, credit} + {1'b0, coin_val};

	// Cancel wins over a coin in the same cycle
	assign cancel_ok = idle && cancel && (credit != '0);
	assign coin_ok   = idle && !cancel && (coin_val != '0) && (credit_sum <= `VEND_CREDIT_MAX);

	always_ff @(posedge can or posedge reset)
	begin
		if (reset)
		begin
			credit  <= '0;
			refund  <= 1'b0;
			ins_cnt <= '{default: '0};
		end
		else
		begin
			refund <= cancel_ok;
			// Transaction ends, dispenser takes the counts this edge
			if (sale || refund)
			begin
				credit  <= '0;
				ins_cnt <= '{default: '0};
			end
			else if (coin_ok)
			begin
				credit <= credit_sum[`VEND_CREDIT_W-1:0];
				if (ins_cnt[coin_idx] != '1)
					ins_cnt[coin_idx] <= ins_cnt[coin_idx] + 1'b1;
			end
		end
	end

	assign ins_5  = ins_cnt[COIN_5];
	assign ins_10 = ins_cnt[COIN_10];
	assign ins_20 = ins_cnt[COIN_20];
	assign ins_50 = ins_cnt[COIN_50];

	assert property (@(posedge can) disable iff (reset) $onehot0(coin_in))
		else $error("coin_in is multi-hot: %b", coin_in);

endmodule

/* rtl/vend_pkg.sv */
`include "vend_config.svh"

package vend_pkg;

	// Denomination index, also the bit position in coin_in and return_coin
	typedef enum logic [1:0]
	{
		COIN_5  = 2'd0,
		COIN_10 = 2'd1,
		COIN_20 = 2'd2,
		COIN_50 = 2'd3
	} coin_e;

	typedef enum logic [1:0]
	{
		DISP_IDLE   = 2'd0,
		DISP_CHANGE = 2'd1,
		DISP_REFUND = 2'd2
	} disp_state_e;

	// Money amounts, credit and change
	typedef logic [`VEND_CREDIT_W-1:0] credit_t;

	// Coin and stock counts, saturating
	typedef logic [`VEND_COUNT_W-1:0] count_t;

endpackage

/* rtl/vend_config.svh */
`ifndef VEND_CONFIG_SVH
`define VEND_CONFIG_SVH

// Datapath widths
`define VEND_CREDIT_W    8
`define VEND_COUNT_W     5

`define VEND_CREDIT_MAX  150

// Product prices
`define VEND_PRICE_0     15
`define VEND_PRICE_1     35
`define VEND_PRICE_2     50
`define VEND_PRICE_3     70

// Coin values
`define VEND_COIN_VAL_5  5
`define VEND_COIN_VAL_10 10
`define VEND_COIN_VAL_20 20
`define VEND_COIN_VAL_50 50

// Machine contents after reset
`define VEND_STOCK_INIT  3
`define VEND_INV_INIT    3

`endif
